//--- logic/cluster_periph_pkg.sv
/*
 * cluster peripheral package
 * shared widths, address map, register offsets and the request and
 * event structs used by every block of the peripheral cluster
 */

package cluster_periph_pkg;

  // **************************************************************************
  // widths and limits
  // **************************************************************************
  localparam int DATA_WIDTH   = 32;
  localparam int ADDR_WIDTH   = 12;
  localparam int OFFSET_WIDTH = 4;
  // first address bit of the word offset, bytes are not addressable
  localparam int OFFSET_LSB   = 2;
  localparam int MAX_CORES    = 8;

  // returned for any read that lands in the unmapped block
  localparam logic [DATA_WIDTH-1:0] UNMAPPED_RDATA = 32'hDEADB33F;

  // **************************************************************************
  // address map
  // **************************************************************************
  // block select, taken from the two top address bits
  typedef enum logic [1:0] {
    SEL_CTRL  = 2'd0,
    SEL_TIMER = 2'd1,
    SEL_EVENT = 2'd2,
    SEL_NONE  = 2'd3
  } periph_sel_e;

  // control unit word offsets
  typedef enum logic [OFFSET_WIDTH-1:0] {
    CTRL_EOC       = 4'd0,
    CTRL_FETCH_EN  = 4'd1,
    CTRL_BOOT_ADDR = 4'd2
  } ctrl_reg_e;

  // timer word offsets
  typedef enum logic [OFFSET_WIDTH-1:0] {
    TIMER_CFG   = 4'd0,
    TIMER_COUNT = 4'd1,
    TIMER_CMP   = 4'd2
  } timer_reg_e;

  // event unit: set selects the buffer, clear selects the mask
  localparam int EV_BUF_BIT = 3;

  // **************************************************************************
  // structs
  // **************************************************************************
  typedef struct packed {
    logic                    valid;
    periph_sel_e             sel;
    logic [OFFSET_WIDTH-1:0] offset;
    logic                    we;
    logic [DATA_WIDTH-1:0]   wdata;
  } periph_req_t;

  // one bit per event source, also the layout of mask and buffer words
  typedef struct packed {
    logic timer;
    logic dma_event;
    logic dma_irq;
  } cluster_evt_t;

endpackage

//--- logic/periph_bus_decode.sv
/*
 * wishbone input side
 * registers one request per bus access and holds off further
 * strobes until the response side acknowledges it
 */

module periph_bus_decode (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic                                        wb_cyc_i,
  input  logic                                        wb_stb_i,
  input  logic                                        wb_we_i,
  input  logic [cluster_periph_pkg::ADDR_WIDTH-1:0]   wb_adr_i,
  input  logic [cluster_periph_pkg::DATA_WIDTH-1:0]   wb_dat_i,
  input  logic                                        wb_ack_i,
  output cluster_periph_pkg::periph_req_t             req_o
);

  typedef enum logic {
    IDLE,
    PENDING
  } state_e;

  state_e state_q;
  logic   accept;
  logic   valid_q;

  cluster_periph_pkg::periph_sel_e                 sel_q;
  logic [cluster_periph_pkg::OFFSET_WIDTH-1:0]     offset_q;
  logic                                            we_q;
  logic [cluster_periph_pkg::DATA_WIDTH-1:0]       wdata_q;

  // a new access is only taken while nothing is outstanding
  assign accept = (state_q == IDLE) && wb_cyc_i && wb_stb_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      valid_q <= 1'b0;
    end else begin
      // valid is a single cycle pulse per access
      valid_q <= accept;
      case (state_q)
        IDLE:    if (accept) state_q <= PENDING;
        PENDING: if (wb_ack_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      sel_q    <= cluster_periph_pkg::periph_sel_e'(
                    wb_adr_i[cluster_periph_pkg::ADDR_WIDTH-1 -: 2]);
      offset_q <= wb_adr_i[cluster_periph_pkg::OFFSET_LSB +:
                           cluster_periph_pkg::OFFSET_WIDTH];
      we_q     <= wb_we_i;
      wdata_q  <= wb_dat_i;
    end
  end

  always_comb begin
    req_o.valid  = valid_q;
    req_o.sel    = sel_q;
    req_o.offset = offset_q;
    req_o.we     = we_q;
    req_o.wdata  = wdata_q;
  end

endmodule

//--- logic/cluster_ctrl_unit.sv
/*
 * cluster control unit
 * end of computation flag, per-core fetch enable and boot address
 */

module cluster_ctrl_unit #(
  parameter int          NB_CORES  = 4,
  parameter logic [31:0] BOOT_ADDR = 32'h1C000000
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  cluster_periph_pkg::periph_req_t           req_i,
  output logic [cluster_periph_pkg::DATA_WIDTH-1:0] rdata_o,
  output logic                                      eoc_o,
  output logic [NB_CORES-1:0]                       fetch_enable_o,
  output logic [31:0]                               boot_addr_o
);

  logic                  wr_en;
  logic                  eoc_q;
  logic [NB_CORES-1:0]   fetch_en_q;
  logic [31:0]           boot_addr_q;

  cluster_periph_pkg::ctrl_reg_e reg_sel;

  assign reg_sel = cluster_periph_pkg::ctrl_reg_e'(req_i.offset);
  assign wr_en   = req_i.valid && req_i.we &&
                   (req_i.sel == cluster_periph_pkg::SEL_CTRL);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= BOOT_ADDR;
    end else if (wr_en) begin
      case (reg_sel)
        cluster_periph_pkg::CTRL_EOC:       eoc_q       <= req_i.wdata[0];
        cluster_periph_pkg::CTRL_FETCH_EN:  fetch_en_q  <= req_i.wdata[NB_CORES-1:0];
        cluster_periph_pkg::CTRL_BOOT_ADDR: boot_addr_q <= req_i.wdata;
        default: ;
      endcase
    end
  end

  // read back, unused offsets give zero
  always_comb begin
    rdata_o = '0;
    case (reg_sel)
      cluster_periph_pkg::CTRL_EOC:       rdata_o[0]            = eoc_q;
      cluster_periph_pkg::CTRL_FETCH_EN:  rdata_o[NB_CORES-1:0] = fetch_en_q;
      cluster_periph_pkg::CTRL_BOOT_ADDR: rdata_o               = boot_addr_q;
      default: ;
    endcase
  end

  assign eoc_o          = eoc_q;
  assign fetch_enable_o = fetch_en_q;
  assign boot_addr_o    = boot_addr_q;

endmodule

//--- logic/cluster_timer.sv
/*
 * cluster timer
 * free running count with compare and reload, pulses one cycle
 * per period of compare value plus one
 */

module cluster_timer (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  cluster_periph_pkg::periph_req_t           req_i,
  output logic [cluster_periph_pkg::DATA_WIDTH-1:0] rdata_o,
  output logic                                      evt_o
);

  logic                                       wr_en;
  logic                                       match;
  logic                                       enable_q;
  logic [cluster_periph_pkg::DATA_WIDTH-1:0]  count_q;
  logic [cluster_periph_pkg::DATA_WIDTH-1:0]  cmp_q;
  logic                                       evt_q;

  cluster_periph_pkg::timer_reg_e reg_sel;

  assign reg_sel = cluster_periph_pkg::timer_reg_e'(req_i.offset);
  assign wr_en   = req_i.valid && req_i.we &&
                   (req_i.sel == cluster_periph_pkg::SEL_TIMER);
  assign match   = (count_q == cmp_q);

  // **************************************************************************
  // configuration
  // **************************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q <= 1'b0;
      cmp_q    <= '0;
    end else if (wr_en) begin
      if (reg_sel == cluster_periph_pkg::TIMER_CFG) enable_q <= req_i.wdata[0];
      if (reg_sel == cluster_periph_pkg::TIMER_CMP) cmp_q    <= req_i.wdata;
    end
  end

  // **************************************************************************
  // counter
  // **************************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
      evt_q   <= 1'b0;
    end else begin
      // pulse lands in the cycle after the match
      evt_q <= enable_q && match;
      // a bus write wins over counting
      if (wr_en && (reg_sel == cluster_periph_pkg::TIMER_COUNT)) begin
        count_q <= req_i.wdata;
      end else if (enable_q) begin
        count_q <= match ? '0 : count_q + 1'b1;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (reg_sel)
      cluster_periph_pkg::TIMER_CFG:   rdata_o[0] = enable_q;
      cluster_periph_pkg::TIMER_COUNT: rdata_o    = count_q;
      cluster_periph_pkg::TIMER_CMP:   rdata_o    = cmp_q;
      default: ;
    endcase
  end

  assign evt_o = evt_q;

endmodule

//--- logic/event_unit.sv
/*
 * event unit
 * sticky per-core event buffers, masked into one interrupt request
 * line per core
 */

module event_unit #(
  parameter int NB_CORES = 4
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  cluster_periph_pkg::periph_req_t           req_i,
  output logic [cluster_periph_pkg::DATA_WIDTH-1:0] rdata_o,
  input  cluster_periph_pkg::cluster_evt_t          evt_i,
  output logic [NB_CORES-1:0]                       irq_req_o
);

  localparam int IDX_WIDTH = $clog2(cluster_periph_pkg::MAX_CORES);
  localparam int EVT_WIDTH = $bits(cluster_periph_pkg::cluster_evt_t);

  logic                                                 wr_en;
  logic                                                 buf_access;
  logic [IDX_WIDTH-1:0]                                 core_idx;
  cluster_periph_pkg::cluster_evt_t                     wr_evt;
  logic [NB_CORES-1:0]                                  mask_we;
  cluster_periph_pkg::cluster_evt_t [NB_CORES-1:0]      buf_clr;
  cluster_periph_pkg::cluster_evt_t [NB_CORES-1:0]      mask_q;
  cluster_periph_pkg::cluster_evt_t [NB_CORES-1:0]      buf_q;

  assign core_idx   = req_i.offset[IDX_WIDTH-1:0];
  assign buf_access = req_i.offset[cluster_periph_pkg::EV_BUF_BIT];
  assign wr_evt     = cluster_periph_pkg::cluster_evt_t'(req_i.wdata[EVT_WIDTH-1:0]);
  assign wr_en      = req_i.valid && req_i.we &&
                      (req_i.sel == cluster_periph_pkg::SEL_EVENT);

  // per-core write strobes, indices past NB_CORES match nothing
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      mask_we[c] = wr_en && !buf_access && (core_idx == c);
      buf_clr[c] = (wr_en && buf_access && (core_idx == c)) ? wr_evt : '0;
    end
  end

  // **************************************************************************
  // mask and sticky buffer
  // **************************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_q <= '0;
      buf_q  <= '0;
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        // new events win over a clear in the same cycle
        buf_q[c] <= (buf_q[c] & ~buf_clr[c]) | evt_i;
        if (mask_we[c]) begin
          mask_q[c] <= wr_evt;
        end
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      if (core_idx == c) begin
        rdata_o[EVT_WIDTH-1:0] = buf_access ? buf_q[c] : mask_q[c];
      end
    end
  end

  // request stays up while any unmasked event is buffered
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      irq_req_o[c] = |(buf_q[c] & mask_q[c]);
    end
  end

endmodule

//--- logic/periph_resp_mux.sv
/*
 * wishbone output side
 * picks the read data of the selected block and registers it together
 * with a single cycle acknowledge
 */

module periph_resp_mux (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  cluster_periph_pkg::periph_req_t           req_i,
  input  logic [cluster_periph_pkg::DATA_WIDTH-1:0] ctrl_rdata_i,
  input  logic [cluster_periph_pkg::DATA_WIDTH-1:0] timer_rdata_i,
  input  logic [cluster_periph_pkg::DATA_WIDTH-1:0] event_rdata_i,
  output logic [cluster_periph_pkg::DATA_WIDTH-1:0] wb_dat_o,
  output logic                                      wb_ack_o
);

  logic [cluster_periph_pkg::DATA_WIDTH-1:0] rdata_sel;
  logic [cluster_periph_pkg::DATA_WIDTH-1:0] dat_q;
  logic                                      ack_q;

  always_comb begin
    case (req_i.sel)
      cluster_periph_pkg::SEL_CTRL:  rdata_sel = ctrl_rdata_i;
      cluster_periph_pkg::SEL_TIMER: rdata_sel = timer_rdata_i;
      cluster_periph_pkg::SEL_EVENT: rdata_sel = event_rdata_i;
      default:                       rdata_sel = cluster_periph_pkg::UNMAPPED_RDATA;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_i.valid;
    end
  end

  // data sampled with the request so it holds through the ack cycle
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      dat_q <= rdata_sel;
    end
  end

  assign wb_dat_o = dat_q;
  assign wb_ack_o = ack_q;

endmodule

//--- logic/cluster_periph_top.sv
/*
 * cluster peripherals top level
 * wishbone slave in front of the control unit, timer and event unit
 */

module cluster_periph_top #(
  parameter int          NB_CORES  = 4,
  parameter logic [31:0] BOOT_ADDR = 32'h1C000000
) (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,

  // wishbone classic slave
  input  logic                                      wb_cyc_i,
  input  logic                                      wb_stb_i,
  input  logic                                      wb_we_i,
  input  logic [cluster_periph_pkg::ADDR_WIDTH-1:0] wb_adr_i,
  input  logic [cluster_periph_pkg::DATA_WIDTH-1:0] wb_dat_i,
  output logic [cluster_periph_pkg::DATA_WIDTH-1:0] wb_dat_o,
  output logic                                      wb_ack_o,

  input  logic                                      dma_cl_event_i,
  input  logic                                      dma_cl_irq_i,

  output logic                                      eoc_o,
  output logic [NB_CORES-1:0]                       fetch_enable_o,
  output logic [31:0]                               boot_addr_o,
  output logic [NB_CORES-1:0]                       irq_req_o
);

  cluster_periph_pkg::periph_req_t           req;
  cluster_periph_pkg::cluster_evt_t          cluster_evt;
  logic [cluster_periph_pkg::DATA_WIDTH-1:0] ctrl_rdata;
  logic [cluster_periph_pkg::DATA_WIDTH-1:0] timer_rdata;
  logic [cluster_periph_pkg::DATA_WIDTH-1:0] event_rdata;
  logic                                      timer_evt;

  // same event vector seen by every core
  always_comb begin
    cluster_evt.timer     = timer_evt;
    cluster_evt.dma_event = dma_cl_event_i;
    cluster_evt.dma_irq   = dma_cl_irq_i;
  end

  // **************************************************************************
  // bus front end
  // **************************************************************************
  periph_bus_decode i_bus_decode (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_we_i  ( wb_we_i  ),
    .wb_adr_i ( wb_adr_i ),
    .wb_dat_i ( wb_dat_i ),
    .wb_ack_i ( wb_ack_o ),
    .req_o    ( req      )
  );

  // **************************************************************************
  // peripherals
  // **************************************************************************
  cluster_ctrl_unit #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) i_ctrl_unit (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .req_i          ( req            ),
    .rdata_o        ( ctrl_rdata     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer i_timer (
    .clk_i    ( clk_i       ),
    .arst_n_i ( arst_n_i    ),
    .req_i    ( req         ),
    .rdata_o  ( timer_rdata ),
    .evt_o    ( timer_evt   )
  );

  event_unit #(
    .NB_CORES ( NB_CORES )
  ) i_event_unit (
    .clk_i     ( clk_i       ),
    .arst_n_i  ( arst_n_i    ),
    .req_i     ( req         ),
    .rdata_o   ( event_rdata ),
    .evt_i     ( cluster_evt ),
    .irq_req_o ( irq_req_o   )
  );

  // **************************************************************************
  // response
  // **************************************************************************
  periph_resp_mux i_resp_mux (
    .clk_i         ( clk_i       ),
    .arst_n_i      ( arst_n_i    ),
    .req_i         ( req         ),
    .ctrl_rdata_i  ( ctrl_rdata  ),
    .timer_rdata_i ( timer_rdata ),
    .event_rdata_i ( event_rdata ),
    .wb_dat_o      ( wb_dat_o    ),
    .wb_ack_o      ( wb_ack_o    )
  );

endmodule

//--- verif/cluster_periph_tb_tasks.svh
/*
 * cluster peripheral testbench helpers
 * wishbone access tasks, lfsr stimulus and error reporting
 */

  // **************************************************************************
  // error reporting
  // **************************************************************************
  task automatic end_in_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[FAIL] time %0t signal %s expected %h actual %h",
             $time, name, expected, actual);
    end_in_failure();
  endtask

  task automatic report_problem(input string what);
    $display("[ERROR] time %0t %s", $time, what);
    end_in_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else report_mismatch(name, expected, actual);
  endtask

  // **************************************************************************
  // stimulus
  // **************************************************************************
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] random_bits(input int width);
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < width; i++) begin
      word       = {word[30:0], lfsr_state[15]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return word;
  endfunction

  function automatic logic [31:0] random_word();
    return random_bits(32);
  endfunction

  function automatic logic [11:0] reg_addr(input cluster_periph_pkg::periph_sel_e sel,
                                           input logic [3:0] offset);
    return {sel, 4'b0000, offset, 2'b00};
  endfunction

  // event unit offset with the buffer flag on top of the core index
  function automatic logic [3:0] ev_offset(input logic is_buf, input int core);
    logic [3:0] offset;
    offset = core[3:0];
    offset[cluster_periph_pkg::EV_BUF_BIT] = is_buf;
    return offset;
  endfunction

  // **************************************************************************
  // wishbone master
  // **************************************************************************
  // called and returns just after a rising edge
  task automatic bus_access(input logic we, input logic [11:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    cycles   = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
    end while (!wb_ack_o && cycles < ACK_TIMEOUT);
    if (!wb_ack_o) begin
      report_problem("the slave never acknowledged the bus access");
    end
    check_value("wb_ack_o latency", 32'd2, cycles);
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    // ack must be gone one cycle later
    @(posedge clk_i);
    #1;
    check_value("wb_ack_o", 32'd0, wb_ack_o);
  endtask

  task automatic bus_write(input logic [11:0] adr, input logic [31:0] wdata);
    logic [31:0] unused_rdata;
    bus_access(1'b1, adr, wdata, unused_rdata);
  endtask

  task automatic check_read(input string name, input logic [11:0] adr,
                            input logic [31:0] expected);
    logic [31:0] rdata;
    bus_access(1'b0, adr, 32'h0, rdata);
    check_value(name, expected, rdata);
  endtask

//--- verif/cluster_periph_tb.sv
/*
 * cluster peripheral testbench
 * walks the control unit, timer and event unit through the wishbone port
 */

module cluster_periph_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NB_CORES      = 4;
  localparam logic [31:0] BOOT_ADDR     = 32'h1C000000;
  localparam int          ACK_TIMEOUT   = 16;
  localparam int          TIMER_N       = 5;
  localparam int          PULSE_TIMEOUT = 4 * (TIMER_N + 1);

  logic                clk_i;
  logic                arst_n_i;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  logic [11:0]         wb_adr_i;
  logic [31:0]         wb_dat_i;
  logic [31:0]         wb_dat_o;
  logic                wb_ack_o;
  logic                dma_cl_event_i;
  logic                dma_cl_irq_i;
  logic                eoc_o;
  logic [NB_CORES-1:0] fetch_enable_o;
  logic [31:0]         boot_addr_o;
  logic [NB_CORES-1:0] irq_req_o;

  logic [15:0] lfsr_state;
  logic [31:0] data;
  logic [31:0] exp_fetch;
  logic [31:0] exp_boot;
  logic [31:0] exp_cmp;
  logic [2:0]  exp_mask [NB_CORES];
  logic [2:0]  exp_buf  [NB_CORES];
  int          gap;

  `include "cluster_periph_tb_tasks.svh"

  cluster_periph_top #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) DUT (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .wb_cyc_i       ( wb_cyc_i       ),
    .wb_stb_i       ( wb_stb_i       ),
    .wb_we_i        ( wb_we_i        ),
    .wb_adr_i       ( wb_adr_i       ),
    .wb_dat_i       ( wb_dat_i       ),
    .wb_dat_o       ( wb_dat_o       ),
    .wb_ack_o       ( wb_ack_o       ),
    .dma_cl_event_i ( dma_cl_event_i ),
    .dma_cl_irq_i   ( dma_cl_irq_i   ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    ),
    .irq_req_o      ( irq_req_o      )
  );

  always #4 clk_i = ~clk_i;

  // ack is one cycle wide and lands two edges after the strobe
  ack_single_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_o |=> !wb_ack_o)
    else report_mismatch("wb_ack_o", 32'd0, 32'd1);

  ack_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(wb_stb_i) |-> ##2 wb_ack_o)
    else report_mismatch("wb_ack_o", 32'd1, 32'd0);

  // irq line per core from the buffer and mask model
  function automatic logic [NB_CORES-1:0] expected_irq();
    logic [NB_CORES-1:0] irq;
    for (int c = 0; c < NB_CORES; c++) begin
      irq[c] = |(exp_buf[c] & exp_mask[c]);
    end
    return irq;
  endfunction

  task automatic wait_timer_pulse(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
    end while (!DUT.timer_evt && cycles < PULSE_TIMEOUT);
    if (!DUT.timer_evt) begin
      report_problem("the timer pulse did not arrive in time");
    end
  endtask

  task automatic pulse_dma(input logic is_irq);
    dma_cl_event_i = !is_irq;
    dma_cl_irq_i   = is_irq;
    @(posedge clk_i);
    #1;
    dma_cl_event_i = 1'b0;
    dma_cl_irq_i   = 1'b0;
  endtask

  initial begin
    clk_i          = 1'b0;
    arst_n_i       = 1'b0;
    wb_cyc_i       = 1'b0;
    wb_stb_i       = 1'b0;
    wb_we_i        = 1'b0;
    wb_adr_i       = '0;
    wb_dat_i       = '0;
    dma_cl_event_i = 1'b0;
    dma_cl_irq_i   = 1'b0;
    lfsr_state     = 16'd95;
    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // reset state
    check_value("eoc_o", 32'd0, eoc_o);
    check_value("fetch_enable_o", 32'd0, fetch_enable_o);
    check_value("irq_req_o", 32'd0, irq_req_o);
    check_value("wb_ack_o", 32'd0, wb_ack_o);
    check_value("boot_addr_o", BOOT_ADDR, boot_addr_o);
    check_read("wb_dat_o boot addr", reg_addr(cluster_periph_pkg::SEL_CTRL,
               cluster_periph_pkg::CTRL_BOOT_ADDR), BOOT_ADDR);

    // ************************************************************************
    // register readback
    // ************************************************************************
    data      = random_word();
    exp_fetch = data & ((32'd1 << NB_CORES) - 1);
    bus_write(reg_addr(cluster_periph_pkg::SEL_CTRL, cluster_periph_pkg::CTRL_FETCH_EN), data);
    check_read("wb_dat_o fetch enable", reg_addr(cluster_periph_pkg::SEL_CTRL,
               cluster_periph_pkg::CTRL_FETCH_EN), exp_fetch);
    check_value("fetch_enable_o", exp_fetch, fetch_enable_o);

    exp_boot = random_word();
    bus_write(reg_addr(cluster_periph_pkg::SEL_CTRL, cluster_periph_pkg::CTRL_BOOT_ADDR),
              exp_boot);
    check_read("wb_dat_o boot addr", reg_addr(cluster_periph_pkg::SEL_CTRL,
               cluster_periph_pkg::CTRL_BOOT_ADDR), exp_boot);
    check_value("boot_addr_o", exp_boot, boot_addr_o);

    bus_write(reg_addr(cluster_periph_pkg::SEL_CTRL, cluster_periph_pkg::CTRL_EOC), 32'd1);
    check_read("wb_dat_o eoc", reg_addr(cluster_periph_pkg::SEL_CTRL,
               cluster_periph_pkg::CTRL_EOC), 32'd1);
    check_value("eoc_o", 32'd1, eoc_o);

    exp_cmp = random_word();
    bus_write(reg_addr(cluster_periph_pkg::SEL_TIMER, cluster_periph_pkg::TIMER_CMP), exp_cmp);
    check_read("wb_dat_o timer cmp", reg_addr(cluster_periph_pkg::SEL_TIMER,
               cluster_periph_pkg::TIMER_CMP), exp_cmp);
    data = random_word();
    bus_write(reg_addr(cluster_periph_pkg::SEL_TIMER, cluster_periph_pkg::TIMER_CFG), data);
    check_read("wb_dat_o timer cfg", reg_addr(cluster_periph_pkg::SEL_TIMER,
               cluster_periph_pkg::TIMER_CFG), {31'd0, data[0]});
    bus_write(reg_addr(cluster_periph_pkg::SEL_TIMER, cluster_periph_pkg::TIMER_CFG), 32'd0);
    // timer stopped, so the count holds what was written
    data = random_word();
    bus_write(reg_addr(cluster_periph_pkg::SEL_TIMER, cluster_periph_pkg::TIMER_COUNT), data);
    check_read("wb_dat_o timer count", reg_addr(cluster_periph_pkg::SEL_TIMER,
               cluster_periph_pkg::TIMER_COUNT), data);

    for (int c = 0; c < NB_CORES; c++) begin
      data        = random_word();
      exp_mask[c] = data[2:0];
      bus_write(reg_addr(cluster_periph_pkg::SEL_EVENT, ev_offset(1'b0, c)), data);
      check_read("wb_dat_o event mask", reg_addr(cluster_periph_pkg::SEL_EVENT,
                 ev_offset(1'b0, c)), {29'd0, exp_mask[c]});
    end
    check_read("wb_dat_o absent core", reg_addr(cluster_periph_pkg::SEL_EVENT,
               ev_offset(1'b0, NB_CORES + 1)), 32'd0);

    // ************************************************************************
    // unmapped block
    // ************************************************************************
    data = random_bits(4);
    check_read("wb_dat_o unmapped", reg_addr(cluster_periph_pkg::SEL_NONE, data[3:0]),
               cluster_periph_pkg::UNMAPPED_RDATA);
    bus_write(reg_addr(cluster_periph_pkg::SEL_NONE, 4'd1), random_word());
    bus_write(reg_addr(cluster_periph_pkg::SEL_NONE, 4'd2), random_word());
    check_value("eoc_o", 32'd1, eoc_o);
    check_value("fetch_enable_o", exp_fetch, fetch_enable_o);
    check_value("boot_addr_o", exp_boot, boot_addr_o);
    check_read("wb_dat_o timer cmp", reg_addr(cluster_periph_pkg::SEL_TIMER,
               cluster_periph_pkg::TIMER_CMP), exp_cmp);
    for (int c = 0; c < NB_CORES; c++) begin
      check_read("wb_dat_o event mask", reg_addr(cluster_periph_pkg::SEL_EVENT,
                 ev_offset(1'b0, c)), {29'd0, exp_mask[c]});
    end

    // ************************************************************************
    // timer events
    // ************************************************************************
    exp_mask = '{3'b100, 3'b010, 3'b001, 3'b000};
    for (int c = 0; c < NB_CORES; c++) begin
      bus_write(reg_addr(cluster_periph_pkg::SEL_EVENT, ev_offset(1'b1, c)), 32'h7);
      bus_write(reg_addr(cluster_periph_pkg::SEL_EVENT, ev_offset(1'b0, c)), exp_mask[c]);
      exp_buf[c] = 3'b000;
    end
    check_value("irq_req_o", expected_irq(), irq_req_o);

    bus_write(reg_addr(cluster_periph_pkg::SEL_TIMER, cluster_periph_pkg::TIMER_CMP), TIMER_N);
    bus_write(reg_addr(cluster_periph_pkg::SEL_TIMER, cluster_periph_pkg::TIMER_COUNT), 32'd0);
    bus_write(reg_addr(cluster_periph_pkg::SEL_TIMER, cluster_periph_pkg::TIMER_CFG), 32'd1);
    wait_timer_pulse(gap);
    wait_timer_pulse(gap);
    check_value("DUT.timer_evt period", TIMER_N + 1, gap);
    bus_write(reg_addr(cluster_periph_pkg::SEL_TIMER, cluster_periph_pkg::TIMER_CFG), 32'd0);
    for (int c = 0; c < NB_CORES; c++) begin
      exp_buf[c] = 3'b100;
    end
    check_value("irq_req_o", expected_irq(), irq_req_o);

    // clearing the timer bit drops core 0 again
    bus_write(reg_addr(cluster_periph_pkg::SEL_EVENT, ev_offset(1'b1, 0)), 32'h4);
    exp_buf[0] = 3'b000;
    check_value("irq_req_o", expected_irq(), irq_req_o);

    // ************************************************************************
    // dma events
    // ************************************************************************
    pulse_dma(1'b0);
    for (int c = 0; c < NB_CORES; c++) begin
      exp_buf[c] = exp_buf[c] | 3'b010;
    end
    check_value("irq_req_o", expected_irq(), irq_req_o);
    pulse_dma(1'b1);
    for (int c = 0; c < NB_CORES; c++) begin
      exp_buf[c] = exp_buf[c] | 3'b001;
    end
    check_value("irq_req_o", expected_irq(), irq_req_o);
    for (int c = 0; c < NB_CORES; c++) begin
      check_read("wb_dat_o event buffer", reg_addr(cluster_periph_pkg::SEL_EVENT,
                 ev_offset(1'b1, c)), {29'd0, exp_buf[c]});
      bus_write(reg_addr(cluster_periph_pkg::SEL_EVENT, ev_offset(1'b1, c)), 32'h7);
      exp_buf[c] = 3'b000;
    end
    check_value("irq_req_o", expected_irq(), irq_req_o);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- sim.f
+incdir+verif
logic/cluster_periph_pkg.sv
logic/periph_bus_decode.sv
logic/cluster_ctrl_unit.sv
logic/cluster_timer.sv
logic/event_unit.sv
logic/periph_resp_mux.sv
logic/cluster_periph_top.sv
verif/cluster_periph_tb.sv
